// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tbDlxControl
RTL_TOP ?= dlxControl
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== filelist.f ====
src/dlxIsaPkg.sv
src/dlxCtrlPkg.sv
src/instrDecoder.sv
src/hazardUnit.sv
src/dlxControl.sv
verif/tbClockGen.sv
verif/tbDlxControl.sv

// ==== src/dlxControl.sv ====
`timescale 1ns/1ns

module dlxControl #(
	parameter dlxIsaPkg::regIdxT LINK_REG = 5'd31
) (
	input logic clk,
	input logic rst,
	input logic instrValid,
	input dlxIsaPkg::instrWordU instr,
	output dlxCtrlPkg::ctrlWordT ctrl,
	output logic stall
);
	import dlxIsaPkg::*;
	import dlxCtrlPkg::*;

	decCtrlT decoded;
	regIdxT srcA;
	regIdxT srcB;

	instrDecoder #(
		.LINK_REG(LINK_REG)
	) dec_i (
		.instr(instr),
		.decoded(decoded),
		.srcA(srcA),
		.srcB(srcB)
	);

	hazardUnit haz_i (
		.clk(clk),
		.rst(rst),
		.instrValid(instrValid),
		.decoded(decoded),
		.srcA(srcA),
		.srcB(srcB),
		.ctrl(ctrl),
		.stall(stall)
	);

endmodule

// ==== src/dlxCtrlPkg.sv ====
package dlxCtrlPkg;

	// bit order is alu0 down to alu5 of the datapath
	typedef enum logic [5:0] {
		ALU_AND = 6'b000000,
		ALU_ADD = 6'b000001,
		ALU_SEQ = 6'b000011,
		ALU_SUB = 6'b000111,
		ALU_SRA = 6'b001000,
		ALU_SLE = 6'b001011,
		ALU_XOR = 6'b010000,
		ALU_SLT = 6'b010011,
		ALU_SLL = 6'b011000,
		ALU_SGE = 6'b011011,
		ALU_OR  = 6'b100000,
		ALU_SNE = 6'b100011,
		ALU_SRL = 6'b101000,
		ALU_SGT = 6'b110011
	} aluOpE;

	typedef struct packed {
		aluOpE aluOp;
		logic aluSrc;          // second operand is imm16
		logic loadHigh;
		logic link;
		logic memWr;
		logic memSign;
		logic [1:0] dataSize;  // 00 byte, 01 half, 11 word
		logic wSrc;            // write back from memory
		logic regWr;
		logic regDst;
		logic isLoad;
		logic beqz;
		logic bnez;
		logic jump;
		logic jumpReg;
		dlxIsaPkg::regIdxT dest;
		logic [15:0] imm16;
	} decCtrlT;

	typedef struct packed {
		logic exMemExA;
		logic exMemExB;
		logic memWbExA;
		logic memWbExB;
		logic memWbMem;  // store data from mem/wb
	} fwdSelT;

	typedef struct packed {
		decCtrlT dec;
		fwdSelT fwd;
	} ctrlWordT;

endpackage

// ==== src/dlxIsaPkg.sv ====
package dlxIsaPkg;

	typedef logic [4:0] regIdxT;

	typedef struct packed {
		logic [5:0] opcode;
		regIdxT rs1;
		regIdxT rs2;
		regIdxT rd;
		logic [4:0] shamt;
		logic [5:0] func;
	} rFmtT;

	typedef struct packed {
		logic [5:0] opcode;
		regIdxT rs1;
		regIdxT rs2;
		logic [15:0] imm16;
	} iFmtT;

	typedef struct packed {
		logic [5:0] opcode;
		logic [25:0] value;
	} jFmtT;

	// one word, three readings
	typedef union packed {
		rFmtT rFmt;
		iFmtT iFmt;
		jFmtT jFmt;
	} instrWordU;

	localparam logic [5:0] OP_RTYPE = 6'b000000;
	localparam logic [5:0] OP_J     = 6'b000010;
	localparam logic [5:0] OP_JAL   = 6'b000011;
	localparam logic [5:0] OP_BEQZ  = 6'b000100;
	localparam logic [5:0] OP_BNEZ  = 6'b000101;
	localparam logic [5:0] OP_ADDI  = 6'b001000;
	localparam logic [5:0] OP_ADDUI = 6'b001001;
	localparam logic [5:0] OP_SUBI  = 6'b001010;
	localparam logic [5:0] OP_SUBUI = 6'b001011;
	localparam logic [5:0] OP_ANDI  = 6'b001100;
	localparam logic [5:0] OP_ORI   = 6'b001101;
	localparam logic [5:0] OP_XORI  = 6'b001110;
	localparam logic [5:0] OP_LHI   = 6'b001111;
	localparam logic [5:0] OP_JR    = 6'b010010;
	localparam logic [5:0] OP_JALR  = 6'b010011;
	localparam logic [5:0] OP_SLLI  = 6'b010100;
	localparam logic [5:0] OP_SRLI  = 6'b010110;
	localparam logic [5:0] OP_SRAI  = 6'b010111;
	localparam logic [5:0] OP_SEQI  = 6'b011000;
	localparam logic [5:0] OP_SNEI  = 6'b011001;
	localparam logic [5:0] OP_SLTI  = 6'b011010;
	localparam logic [5:0] OP_SGTI  = 6'b011011;
	localparam logic [5:0] OP_SLEI  = 6'b011100;
	localparam logic [5:0] OP_SGEI  = 6'b011101;
	localparam logic [5:0] OP_LB    = 6'b100000;  // low two bits give dataSize
	localparam logic [5:0] OP_LH    = 6'b100001;
	localparam logic [5:0] OP_LW    = 6'b100011;
	localparam logic [5:0] OP_LBU   = 6'b100100;
	localparam logic [5:0] OP_LHU   = 6'b100101;
	localparam logic [5:0] OP_SB    = 6'b101000;
	localparam logic [5:0] OP_SH    = 6'b101001;
	localparam logic [5:0] OP_SW    = 6'b101011;

	localparam logic [5:0] FN_SLL  = 6'b000100;
	localparam logic [5:0] FN_SRL  = 6'b000110;
	localparam logic [5:0] FN_SRA  = 6'b000111;
	localparam logic [5:0] FN_ADD  = 6'b100000;
	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUB  = 6'b100010;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_AND  = 6'b100100;
	localparam logic [5:0] FN_OR   = 6'b100101;
	localparam logic [5:0] FN_XOR  = 6'b100110;
	localparam logic [5:0] FN_SEQ  = 6'b101000;
	localparam logic [5:0] FN_SNE  = 6'b101001;
	localparam logic [5:0] FN_SLT  = 6'b101010;
	localparam logic [5:0] FN_SGT  = 6'b101011;
	localparam logic [5:0] FN_SLE  = 6'b101100;
	localparam logic [5:0] FN_SGE  = 6'b101101;

	localparam logic [31:0] NOP_WORD = 32'h0000_0015;  // r-type, func 0x15

endpackage

// ==== src/hazardUnit.sv ====
`timescale 1ns/1ns

module hazardUnit (
	input logic clk,
	input logic rst,
	input logic instrValid,
	input dlxCtrlPkg::decCtrlT decoded,
	input dlxIsaPkg::regIdxT srcA,
	input dlxIsaPkg::regIdxT srcB,
	output dlxCtrlPkg::ctrlWordT ctrl,
	output logic stall
);
	import dlxIsaPkg::*;
	import dlxCtrlPkg::*;

	typedef struct packed {
		regIdxT dest;
		logic regWr;  // already gated by stall
		logic isLoad;
		logic stall;
	} slotT;

	slotT slot1;  // previous strobe
	slotT slot2;  // one before that
	fwdSelT fwd;
	logic hit1A;
	logic hit1B;
	logic hit2A;
	logic hit2B;
	logic isBranch;

	assign hit1A = instrValid && srcA != '0 && slot1.regWr && slot1.dest == srcA;
	assign hit1B = instrValid && srcB != '0 && slot1.regWr && slot1.dest == srcB;
	assign hit2A = instrValid && srcA != '0 && slot2.regWr && slot2.dest == srcA;
	assign hit2B = instrValid && srcB != '0 && slot2.regWr && slot2.dest == srcB;
	assign isBranch = decoded.beqz | decoded.bnez;

	always_comb
	begin
		fwd = '0;
		stall = 1'b0;

		fwd.exMemExA = hit1A;
		if (hit1A && slot1.isLoad)
		begin
			fwd.memWbExA = 1'b1;
			stall = 1'b1;  // load-use
		end
		if (hit2A && slot2.isLoad)
			fwd.memWbExA = 1'b1;

		if (decoded.memWr)
		begin
			fwd.memWbMem = hit1B;
		end
		else
		begin
			fwd.exMemExB = hit1B;
			if (hit1B && slot1.isLoad)
			begin
				fwd.memWbExB = 1'b1;
				stall = 1'b1;
			end
			if (hit2B && slot2.isLoad)
				fwd.memWbExB = 1'b1;
		end

		// branch resolves in decode, so it waits one strobe
		if (isBranch && hit1A)
			stall = 1'b1;
	end

	always_comb
	begin
		ctrl.dec = decoded;
		ctrl.dec.regWr = decoded.regWr & ~stall;  // bubble
		ctrl.fwd = fwd;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			slot1 <= '0;
			slot2 <= '0;
		end
		else if (instrValid)
		begin
			slot2 <= slot1;
			slot1 <= '{
				dest: decoded.dest,
				regWr: decoded.regWr & ~stall,
				isLoad: decoded.isLoad,
				stall: stall
			};
		end
	end

	// the reissue after a stall sees a bubble in slot1
	stallOnce: assert property (@(posedge clk) disable iff (rst)
		(instrValid && slot1.stall) |-> !stall)
		else $error("stall raised on two strobes in a row");

	// history stays empty from reset until something issues
	emptyAfterReset: assert property (@(posedge clk)
		(rst || (!instrValid && !slot1.regWr && !slot2.regWr))
		|=> (!slot1.regWr && !slot2.regWr))
		else $error("history holds a write without a strobe");

endmodule

// ==== src/instrDecoder.sv ====
`timescale 1ns/1ns

module instrDecoder #(
	parameter dlxIsaPkg::regIdxT LINK_REG = 5'd31
) (
	input dlxIsaPkg::instrWordU instr,
	output dlxCtrlPkg::decCtrlT decoded,
	output dlxIsaPkg::regIdxT srcA,
	output dlxIsaPkg::regIdxT srcB
);
	import dlxIsaPkg::*;
	import dlxCtrlPkg::*;

	logic [5:0] opcode;
	aluOpE funcOp;
	aluOpE immOp;
	logic funcKnown;

	assign opcode = instr.rFmt.opcode;

	always_comb
	begin
		funcKnown = 1'b1;
		case (instr.rFmt.func)
			FN_ADD, FN_ADDU: funcOp = ALU_ADD;
			FN_SUB, FN_SUBU: funcOp = ALU_SUB;
			FN_AND: funcOp = ALU_AND;
			FN_OR: funcOp = ALU_OR;
			FN_XOR: funcOp = ALU_XOR;
			FN_SEQ: funcOp = ALU_SEQ;
			FN_SNE: funcOp = ALU_SNE;
			FN_SLT: funcOp = ALU_SLT;
			FN_SGT: funcOp = ALU_SGT;
			FN_SLE: funcOp = ALU_SLE;
			FN_SGE: funcOp = ALU_SGE;
			FN_SLL: funcOp = ALU_SLL;
			FN_SRA: funcOp = ALU_SRA;
			FN_SRL: funcOp = ALU_SRL;
			default:
			begin
				funcOp = ALU_ADD;
				funcKnown = 1'b0;  // nop lands here too
			end
		endcase
	end

	always_comb
	begin
		case (opcode)
			OP_ADDI, OP_ADDUI: immOp = ALU_ADD;
			OP_SUBI, OP_SUBUI: immOp = ALU_SUB;
			OP_ANDI: immOp = ALU_AND;
			OP_ORI: immOp = ALU_OR;
			OP_XORI: immOp = ALU_XOR;
			OP_SEQI: immOp = ALU_SEQ;
			OP_SNEI: immOp = ALU_SNE;
			OP_SLTI: immOp = ALU_SLT;
			OP_SGTI: immOp = ALU_SGT;
			OP_SLEI: immOp = ALU_SLE;
			OP_SGEI: immOp = ALU_SGE;
			OP_SLLI: immOp = ALU_SLL;
			OP_SRAI: immOp = ALU_SRA;
			OP_SRLI: immOp = ALU_SRL;
			default: immOp = ALU_ADD;  // address and link adds
		endcase
	end

	always_comb
	begin
		decoded = '0;
		decoded.aluOp = ALU_ADD;
		decoded.aluSrc = |opcode[5:3];
		decoded.memWr = (opcode[5:3] == 3'b101);
		decoded.wSrc = (opcode[5:3] == 3'b100);
		decoded.memSign = 1'b1;
		decoded.dataSize = opcode[1:0];
		decoded.imm16 = instr.iFmt.imm16;
		srcA = '0;  // register 0 never matches
		srcB = '0;

		case (opcode)
			OP_RTYPE:
			begin
				decoded.regDst = 1'b1;
				decoded.aluOp = funcOp;
				srcA = instr.rFmt.rs1;
				srcB = instr.rFmt.rs2;
				if (instr != NOP_WORD && funcKnown)
				begin
					decoded.regWr = 1'b1;
					decoded.dest = instr.rFmt.rd;
				end
			end

			OP_ADDI, OP_ADDUI, OP_SUBI, OP_SUBUI, OP_ANDI, OP_ORI, OP_XORI,
			OP_SEQI, OP_SNEI, OP_SLTI, OP_SGTI, OP_SLEI, OP_SGEI,
			OP_SLLI, OP_SRAI, OP_SRLI:
			begin
				decoded.aluOp = immOp;
				decoded.regWr = 1'b1;
				decoded.dest = instr.iFmt.rs2;
				srcA = instr.iFmt.rs1;
			end

			OP_LHI:
			begin
				decoded.loadHigh = 1'b1;
				decoded.regWr = 1'b1;
				decoded.dest = instr.iFmt.rs2;
			end

			OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU:
			begin
				decoded.isLoad = 1'b1;
				decoded.regWr = 1'b1;
				decoded.memSign = ~opcode[2];  // lbu, lhu zero extend
				decoded.dest = instr.iFmt.rs2;
				srcA = instr.iFmt.rs1;
			end

			OP_SB, OP_SH, OP_SW:
			begin
				srcA = instr.iFmt.rs1;  // base
				srcB = instr.iFmt.rs2;  // store data
			end

			OP_BEQZ:
			begin
				decoded.beqz = 1'b1;
				srcA = instr.iFmt.rs1;
			end

			OP_BNEZ:
			begin
				decoded.bnez = 1'b1;
				srcA = instr.iFmt.rs1;
			end

			OP_J, OP_JAL:
			begin
				decoded.jump = 1'b1;
				if (opcode == OP_JAL)
				begin
					decoded.link = 1'b1;
					decoded.regWr = 1'b1;
					decoded.dest = LINK_REG;
				end
			end

			OP_JR, OP_JALR:
			begin
				decoded.jump = 1'b1;
				decoded.jumpReg = 1'b1;
				srcA = instr.iFmt.rs1;
				if (opcode == OP_JALR)
				begin
					decoded.link = 1'b1;
					decoded.dest = LINK_REG;
				end
			end

			default:
			begin
				decoded.regWr = 1'b0;  // unknown opcode issues as a bubble
			end
		endcase
	end

	always_comb
	begin
		assert final (!(decoded.beqz && decoded.bnez)
			&& !(decoded.jump && (decoded.beqz || decoded.bnez)))
			else $error("overlapping branch and jump flags");
	end

endmodule

// ==== verif/dlxControl_golden.txt ====
# kind group instr ctrl stall  (all hex except group and stall)
# kind S issues a strobe, R applies reset first
S 1 00221820 021180630400 0
S 1 00222022 0E1180840440 0
S 1 00222826 201180A504C0 0
S 1 00223004 301180C60080 0
S 1 0022382B 661180E70560 0
S 1 20280005 0311010000A0 0
S 1 68490003 271901200060 0
S 1 5C2A0002 111D01400040 0
S 2 802B0004 031341600080 0
S 2 942C0006 0307418000C0 0
S 2 AC220008 033C00000100 0
S 2 3C0D1234 039D01A24680 0
S 2 08000040 021808000800 0
S 2 0C000080 025D0BE01000 0
S 2 48200000 03180C000000 0
S 2 4C400000 035C0FE00000 0
S 2 10200010 021020000200 0
S 2 14400020 021410000400 0
S 3 00227020 021181CE0400 0
S 3 01C17822 0E1181EF0450 0
S 3 006E8025 4011821004A0 0
S 3 20200001 031100000020 0
S 3 00108824 001182310480 0
S 4 8C320000 031F42400000 0
S 4 02429820 021082730414 1
S 4 02429820 021182730404 0
S 5 20340007 0311028000E0 0
S 5 12800004 021020000090 1
S 5 12800004 021020000080 0
S 5 20350001 031102A00020 0
S 5 AC750000 033C00000001 0
S 6 20360002 031102C00040 0
R 6 02C2B820 021182F70400 0

// ==== verif/tbClockGen.sv ====
`timescale 1ns/1ns

module tbClockGen #(
	parameter int PERIOD = 40,
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic rst
);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;  // released on the last reset edge
	end

endmodule

// ==== verif/tbDlxControl.sv ====
`timescale 1ns/1ns

module tbDlxControl;
	import dlxIsaPkg::*;
	import dlxCtrlPkg::*;

	localparam string GOLDEN_FILE = "verif/dlxControl_golden.txt";
	localparam int IDLE_GAP = 2;  // idle cycles between groups

	logic clk;
	logic porRst;
	logic midRst;
	logic rst;
	logic instrValid;
	instrWordU instr;
	ctrlWordT ctrl;
	logic stall;

	logic [7:0] kindQ[$];
	int groupQ[$];
	logic [31:0] instrQ[$];
	logic [47:0] ctrlQ[$];
	logic stallQ[$];

	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int cycleLimit = 0;

	assign rst = porRst | midRst;

	tbClockGen clkGen_i (
		.clk(clk),
		.rst(porRst)
	);

	dlxControl #(
		.LINK_REG(5'd31)
	) dut_i (
		.clk(clk),
		.rst(rst),
		.instrValid(instrValid),
		.instr(instr),
		.ctrl(ctrl),
		.stall(stall)
	);

	task automatic checkValue(input logic [63:0] got, input logic [63:0] exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	function automatic string groupName(input int grp);
		case (grp)
			1: return "alu decode";
			2: return "memory and jump decode";
			3: return "alu forwarding";
			4: return "load-use";
			5: return "branch and store hazards";
			6: return "reset";
			default: return "unnamed";
		endcase
	endfunction

	task automatic readGolden();
		int fd;
		int n;
		string line;
		logic [7:0] kind;
		int grp;
		logic [31:0] word;
		logic [47:0] expCtrl;
		int expStall;
		fd = $fopen(GOLDEN_FILE, "r");
		if (fd == 0)
		begin
			errors++;
			$display("could not open the golden file %s", GOLDEN_FILE);
		end
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				n = $fgets(line, fd);
				if (n > 0 && line.len() > 1 && line[0] != 8'h23)  // skip # lines
				begin
					if ($sscanf(line, "%c %d %h %h %d", kind, grp, word, expCtrl, expStall) == 5)
					begin
						kindQ.push_back(kind);
						groupQ.push_back(grp);
						instrQ.push_back(word);
						ctrlQ.push_back(expCtrl);
						stallQ.push_back(expStall != 0);
					end
					else
					begin
						errors++;
						$display("golden file line could not be parsed: %s", line);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic applyReset();
		midRst = 1'b1;
		repeat (3) @(negedge clk);
		midRst = 1'b0;
	endtask

	task automatic idleCycles(input int count);
		repeat (count)
		begin
			@(posedge clk);
			checkValue({63'd0, stall}, 64'd0, "stall while idle");
			@(negedge clk);
		end
	endtask

	task automatic issueStrobe(input int idx);
		instr = instrQ[idx];
		instrValid = 1'b1;
		@(posedge clk);
		checkValue({17'd0, ctrl}, {16'd0, ctrlQ[idx]}, $sformatf("strobe %0d ctrl", idx + 1));
		checkValue({63'd0, stall}, {63'd0, stallQ[idx]}, $sformatf("strobe %0d stall", idx + 1));
		@(negedge clk);
		instrValid = 1'b0;
	endtask

	task automatic reportGroup(input int grp, input int strobes, input int groupErrors);
		$display("group %0d (%s): %0d strobes, %0d errors", grp, groupName(grp), strobes,
			groupErrors);
	endtask

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycleLimit > 0 && cycles >= cycleLimit)
		begin
			$display("run did not finish within %0d cycles", cycleLimit);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	initial
	begin
		int prevGroup;
		int groupStrobes;
		int startErrors;
		instrValid = 1'b0;
		instr = NOP_WORD;
		midRst = 1'b0;
		readGolden();
		cycleLimit = 4 * instrQ.size() + 20;
		prevGroup = (instrQ.size() > 0) ? groupQ[0] : 0;
		groupStrobes = 0;
		startErrors = errors;
		@(negedge clk);
		while (porRst)
			@(negedge clk);
		for (int i = 0; i < instrQ.size(); i++)
		begin
			if (groupQ[i] != prevGroup)
			begin
				reportGroup(prevGroup, groupStrobes, errors - startErrors);
				startErrors = errors;
				groupStrobes = 0;
				prevGroup = groupQ[i];
				idleCycles(IDLE_GAP);
			end
			if (kindQ[i] == "R")
				applyReset();
			issueStrobe(i);
			groupStrobes++;
		end
		reportGroup(prevGroup, groupStrobes, errors - startErrors);
		$display("%0d strobes, %0d checks, %0d errors", instrQ.size(), checks, errors);
		if (errors == 0 && instrQ.size() > 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule
